// ==== compile.f ====
+incdir+design
design/rtttl_pkg.sv
design/note_timer.sv
design/song_rom.sv
design/sequencer_fsm.sv
design/rtttl_sequencer.sv
test/rtttl_tb.sv

// ==== test/rtttl_tb.sv ====
`timescale 1ns/10ps
`include "rtttl_macros.svh"

module rtttl_tb;

  import rtttl_pkg::*;

  localparam int unsigned tick_max    = 9;
  localparam int unsigned tick_period = tick_max + 1;
  localparam int unsigned ref_steps   = 8;
  // every SONG_ONE step lasts eight ticks plus one
  localparam int unsigned song1_ticks = `RTTTL_SONG1_LEN * 9;

  typedef struct packed {
    logic [`RTTTL_DUR_W-1:0]  duration;
    logic [`RTTTL_TONE_W-1:0] octave;
    logic [`RTTTL_TONE_W-1:0] note;
  } ref_step_t;

  logic                     clk;
  logic                     rstn;
  logic                     start;
  logic [1:0]               demo;
  logic [`RTTTL_TONE_W-1:0] octave;
  logic [`RTTTL_TONE_W-1:0] note;

  int unsigned cyc;
  logic [31:0] rng_state;

  rtttl_sequencer #(
    .tick_max(tick_max)
  ) dut_i (
    .clk   (clk),
    .rstn  (rstn),
    .start (start),
    .demo  (demo),
    .octave(octave),
    .note  (note)
  );

  always #2 clk = ~clk;

  // cycles since reset release, a tick edge lands where cyc is a multiple of tick_period
  always @(posedge clk) begin
    if (!rstn) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  function automatic ref_step_t ref_step(input song_e song, input int unsigned idx);
    ref_step_t s;
    s = '0;
    if (song == SONG_ONE) begin
      case (idx)
        0, 1, 2: s = {6'd8, 4'd5, 4'd6};
        3: s = {6'd8, 4'd5, 4'd2};
        4: s = {6'd8, 4'd4, 4'd12};
        5: s = {6'd8, 4'd4, 4'd11};
        6: s = {6'd8, 4'd4, 4'd12};
        7: s = {6'd8, 4'd5, 4'd4};
        `RTTTL_SONG1_LEN - 1: s = {6'd8, 4'd5, 4'd4};
        default: s = '0;
      endcase
    end else begin
      case (idx)
        0: s = {6'd16, 4'd4, 4'd7};
        1: s = {6'd16, 4'd4, 4'd9};
        2: s = {6'd16, 4'd4, 4'd11};
        3: s = {6'd16, 4'd6, 4'd0};
        4: s = {6'd16, 4'd6, 4'd2};
        5: s = {6'd16, 4'd6, 4'd4};
        6: s = {6'd16, 4'd6, 4'd5};
        7: s = {6'd8, 4'd6, 4'd7};
        `RTTTL_SONG0_LEN - 1: s = {6'd4, 4'd6, 4'd0};
        default: s = '0;
      endcase
    end
    return s;
  endfunction

  function automatic int unsigned ref_song_len(input song_e song);
    return (song == SONG_ONE) ? `RTTTL_SONG1_LEN : `RTTTL_SONG0_LEN;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] cur_tone();
    return {octave, note};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
    end
  endtask

  // inputs change 1 ns after the edge, outputs are read at the falling edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic sample_point();
    @(negedge clk);
  endtask

  task automatic advance();
    next_cycle();
    sample_point();
  endtask

  task automatic apply_reset();
    rstn  = 1'b0;
    start = 1'b0;
    repeat (2) next_cycle();
    rstn = 1'b1;
    sample_point();
  endtask

  task automatic hold_tone(input string name, input int unsigned n, input logic [7:0] exp);
    repeat (n) begin
      check_value(name, exp, cur_tone());
      advance();
    end
  endtask

  task automatic random_gap(input string name, input logic [7:0] exp);
    rng_state = xorshift32(rng_state);
    hold_tone(name, (rng_state % 13) + 1, exp);
  endtask

  task automatic pulse_start(input logic [1:0] dm, output int unsigned start_cyc);
    next_cycle();
    demo  = dm;
    start = 1'b1;
    sample_point();
    start_cyc = cyc;
    next_cycle();
    start = 1'b0;
    sample_point();
  endtask

  task automatic wait_first_tone(input string name, input int unsigned start_cyc,
                                 input logic [7:0] idle_tone, output int unsigned first_cyc);
    int unsigned waited;
    int unsigned expect_cyc;
    waited = 0;
    // the first tick edge after the FSM has entered play
    expect_cyc = ((start_cyc + 2 + tick_period - 1) / tick_period) * tick_period;
    while (cur_tone() === idle_tone) begin
      if (waited >= tick_period + 4) begin
        fail_run($sformatf("%s never left the idle tone after start", name));
      end else begin
        advance();
        waited++;
      end
    end
    first_cyc = cyc;
    check_value({name, " first tone cycle"}, expect_cyc, first_cyc);
  endtask

  // walks the reference steps cycle by cycle, poke_at >= 0 raises start once mid-song
  task automatic check_steps(input string name, input song_e song, input int poke_at);
    ref_step_t exp;
    int unsigned n;
    int elapsed;
    elapsed = 0;
    for (int unsigned i = 0; i < ref_steps; i++) begin
      exp = ref_step(song, i);
      n = (exp.duration + 1) * tick_period;
      for (int unsigned k = 0; k < n; k++) begin
        check_value($sformatf("%s step %0d", name, i), {exp.octave, exp.note}, cur_tone());
        next_cycle();
        start = (elapsed == poke_at);
        if (elapsed == poke_at) begin
          demo = 2'b10;
        end
        sample_point();
        elapsed++;
      end
    end
  endtask

  task automatic check_song_end(input string name, input song_e song,
                                input int unsigned first_cyc, input int unsigned total_ticks);
    ref_step_t last;
    logic [7:0] prev;
    int unsigned waited;
    last = ref_step(song, ref_song_len(song) - 1);
    prev = cur_tone();
    waited = 0;
    while (cur_tone() !== 8'h00) begin
      if (waited >= (total_ticks + 2) * tick_period) begin
        fail_run($sformatf("%s never returned to the idle tone", name));
      end else begin
        prev = cur_tone();
        advance();
        waited++;
      end
    end
    check_value({name, " final tone"}, {last.octave, last.note}, prev);
    check_value({name, " idle cycle"}, first_cyc + total_ticks * tick_period, cyc);
    hold_tone({name, " idle hold"}, 5 * tick_period, 8'h00);
  endtask

  initial begin
    int unsigned start_cyc;
    int unsigned first_cyc;
    clk         = 1'b0;
    rstn        = 1'b0;
    start       = 1'b0;
    demo        = 2'b00;
    rng_state   = 32'h730d;

    apply_reset();
    hold_tone("reset idle", 6 * tick_period, 8'h0f);

    random_gap("song zero gap", 8'h0f);
    pulse_start(2'b01, start_cyc);
    wait_first_tone("song zero", start_cyc, 8'h0f, first_cyc);
    check_steps("song zero", SONG_ZERO, -1);

    next_cycle();
    apply_reset();
    random_gap("song one gap", 8'h0f);
    pulse_start(2'b10, start_cyc);
    wait_first_tone("song one", start_cyc, 8'h0f, first_cyc);
    check_steps("song one", SONG_ONE, -1);
    check_song_end("song one end", SONG_ONE, first_cyc, song1_ticks);

    // replay after the end, outputs now sit at 0/0
    random_gap("replay gap", 8'h00);
    pulse_start(2'b01, start_cyc);
    wait_first_tone("replay", start_cyc, 8'h00, first_cyc);
    check_steps("replay", SONG_ZERO, -1);

    next_cycle();
    apply_reset();
    random_gap("restart gap", 8'h0f);
    pulse_start(2'b01, start_cyc);
    wait_first_tone("start during play", start_cyc, 8'h0f, first_cyc);
    check_steps("start during play", SONG_ZERO, 3 * tick_period + 4);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== design/rtttl_sequencer.sv ====
`timescale 1ns/10ps
`include "rtttl_macros.svh"

module rtttl_sequencer #(
  parameter int unsigned tick_max = `RTTTL_TICK_MAX
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start,
  input  logic [1:0]               demo,
  output logic [`RTTTL_TONE_W-1:0] octave,
  output logic [`RTTTL_TONE_W-1:0] note
);

  import rtttl_pkg::*;

  song_e                    song;
  logic [`RTTTL_ADDR_W-1:0] addr;
  step_t                    step;
  tone_t                    tone;
  logic                     run;
  logic                     load;
  logic                     step_due;

  note_timer #(
    .tick_max(tick_max)
  ) timer_i (
    .clk          (clk),
    .rstn         (rstn),
    .run          (run),
    .load         (load),
    .load_duration(step.duration),
    .step_due     (step_due)
  );

  song_rom rom_i (
    .song(song),
    .addr(addr),
    .step(step)
  );

  sequencer_fsm fsm_i (
    .clk     (clk),
    .rstn    (rstn),
    .start   (start),
    .demo    (demo),
    .step    (step),
    .step_due(step_due),
    .song    (song),
    .addr    (addr),
    .run     (run),
    .load    (load),
    .tone    (tone)
  );

  assign octave = tone.octave;
  assign note   = tone.note;

endmodule

// ==== design/sequencer_fsm.sv ====
`timescale 1ns/10ps
`include "rtttl_macros.svh"

module sequencer_fsm (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start,
  input  logic [1:0]               demo,
  input  rtttl_pkg::step_t         step,
  input  logic                     step_due,
  output rtttl_pkg::song_e         song,
  output logic [`RTTTL_ADDR_W-1:0] addr,
  output logic                     run,
  output logic                     load,
  output rtttl_pkg::tone_t         tone
);

  import rtttl_pkg::*;

  // addr may sit one past the last step of the longer song
  localparam int unsigned max_len = (`RTTTL_SONG0_LEN > `RTTTL_SONG1_LEN) ?
                                    `RTTTL_SONG0_LEN : `RTTTL_SONG1_LEN;
  localparam logic [`RTTTL_ADDR_W-1:0] addr_limit = max_len[`RTTTL_ADDR_W-1:0];

  seq_state_e state;

  assign run  = (state == SEQ_PLAY);
  // step boundary with a real step behind it, reload the countdown
  assign load = step_due && step.valid;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= SEQ_IDLE;
      song        <= SONG_ZERO;
      addr        <= '0;
      tone.octave <= '0;
      tone.note   <= '1;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            song  <= (demo == 2'b10) ? SONG_ONE : SONG_ZERO;
            state <= SEQ_PLAY;
          end
        end
        SEQ_PLAY: begin
          // start is ignored here, the song always plays out
          if (step_due) begin
            if (step.valid) begin
              tone <= step.tone;
              addr <= addr + 1'b1;
            end else begin
              tone  <= '0;
              addr  <= '0;
              state <= SEQ_IDLE;
            end
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  addr_in_range: assert property (@(posedge clk) disable iff (!rstn) addr <= addr_limit)
    else $error("step address ran past the longest song");

  // the timer must not report a step boundary while idle
  load_only_playing: assert property (@(posedge clk) disable iff (!rstn)
    load |-> (state == SEQ_PLAY))
    else $error("load fired outside of playback");

endmodule

// ==== design/song_rom.sv ====
`timescale 1ns/10ps
`include "rtttl_macros.svh"

module song_rom (
  input  rtttl_pkg::song_e         song,
  input  logic [`RTTTL_ADDR_W-1:0] addr,
  output rtttl_pkg::step_t         step
);

  import rtttl_pkg::*;

  function automatic step_t mk(input int unsigned dur, input int unsigned oct,
                               input int unsigned nt);
    step_t s;
    s.valid       = 1'b1;
    s.duration    = dur[`RTTTL_DUR_W-1:0];
    s.tone.octave = oct[`RTTTL_TONE_W-1:0];
    s.tone.note   = nt[`RTTTL_TONE_W-1:0];
    return s;
  endfunction

  always_comb begin
    // anything past the end reads back as an invalid step
    step = '0;
    if (song == SONG_ONE) begin
      case (addr)
        8'd0:  step = mk(8, 5, 6);
        8'd1:  step = mk(8, 5, 6);
        8'd2:  step = mk(8, 5, 6);
        8'd3:  step = mk(8, 5, 2);
        8'd4:  step = mk(8, 4, 12);
        8'd5:  step = mk(8, 4, 11);
        8'd6:  step = mk(8, 4, 12);
        8'd7:  step = mk(8, 5, 4);
        8'd8:  step = mk(8, 4, 12);
        8'd9:  step = mk(8, 5, 4);
        8'd10: step = mk(8, 4, 12);
        8'd11: step = mk(8, 5, 4);
        8'd12: step = mk(8, 5, 8);
        8'd13: step = mk(8, 5, 8);
        8'd14: step = mk(8, 5, 9);
        8'd15: step = mk(8, 5, 11);
        8'd16: step = mk(8, 5, 9);
        8'd17: step = mk(8, 5, 9);
        8'd18: step = mk(8, 5, 9);
        8'd19: step = mk(8, 5, 4);
        8'd20: step = mk(8, 4, 12);
        8'd21: step = mk(8, 5, 2);
        8'd22: step = mk(8, 4, 12);
        8'd23: step = mk(8, 5, 6);
        8'd24: step = mk(8, 4, 12);
        8'd25: step = mk(8, 5, 6);
        8'd26: step = mk(8, 4, 12);
        8'd27: step = mk(8, 5, 6);
        8'd28: step = mk(8, 5, 4);
        8'd29: step = mk(8, 5, 4);
        8'd30: step = mk(8, 5, 6);
        8'd31: step = mk(8, 5, 4);
        // second verse repeats the first
        8'd32: step = mk(8, 5, 6);
        8'd33: step = mk(8, 5, 6);
        8'd34: step = mk(8, 5, 6);
        8'd35: step = mk(8, 5, 2);
        8'd36: step = mk(8, 4, 12);
        8'd37: step = mk(8, 4, 11);
        8'd38: step = mk(8, 4, 12);
        8'd39: step = mk(8, 5, 4);
        8'd40: step = mk(8, 4, 12);
        8'd41: step = mk(8, 5, 4);
        8'd42: step = mk(8, 4, 12);
        8'd43: step = mk(8, 5, 4);
        8'd44: step = mk(8, 5, 8);
        8'd45: step = mk(8, 5, 8);
        8'd46: step = mk(8, 5, 9);
        8'd47: step = mk(8, 5, 11);
        8'd48: step = mk(8, 5, 9);
        8'd49: step = mk(8, 5, 9);
        8'd50: step = mk(8, 5, 9);
        8'd51: step = mk(8, 5, 4);
        8'd52: step = mk(8, 4, 12);
        8'd53: step = mk(8, 5, 2);
        8'd54: step = mk(8, 4, 12);
        8'd55: step = mk(8, 5, 6);
        8'd56: step = mk(8, 4, 12);
        8'd57: step = mk(8, 5, 6);
        8'd58: step = mk(8, 4, 12);
        8'd59: step = mk(8, 5, 6);
        8'd60: step = mk(8, 5, 4);
        8'd61: step = mk(8, 5, 4);
        default: step = '0;
      endcase
    end else begin
      case (addr)
        8'd0:  step = mk(16, 4, 7);
        8'd1:  step = mk(16, 4, 9);
        8'd2:  step = mk(16, 4, 11);
        8'd3:  step = mk(16, 6, 0);
        8'd4:  step = mk(16, 6, 2);
        8'd5:  step = mk(16, 6, 4);
        8'd6:  step = mk(16, 6, 5);
        8'd7:  step = mk(8, 6, 7);
        8'd8:  step = mk(8, 4, 0);
        8'd9:  step = mk(8, 6, 0);
        8'd10: step = mk(8, 4, 4);
        8'd11: step = mk(8, 4, 5);
        8'd12: step = mk(8, 7, 0);
        8'd13: step = mk(8, 4, 7);
        8'd14: step = mk(8, 6, 9);
        8'd15: step = mk(8, 6, 7);
        8'd16: step = mk(8, 4, 0);
        8'd17: step = mk(8, 6, 0);
        8'd18: step = mk(8, 4, 4);
        8'd19: step = mk(8, 4, 5);
        8'd20: step = mk(8, 6, 7);
        8'd21: step = mk(8, 4, 7);
        8'd22: step = mk(8, 6, 5);
        8'd23: step = mk(8, 6, 4);
        8'd24: step = mk(8, 6, 4);
        8'd25: step = mk(8, 6, 5);
        8'd26: step = mk(8, 6, 7);
        8'd27: step = mk(8, 6, 0);
        8'd28: step = mk(8, 4, 5);
        8'd29: step = mk(8, 6, 2);
        8'd30: step = mk(8, 4, 7);
        8'd31: step = mk(8, 6, 4);
        8'd32: step = mk(8, 4, 0);
        8'd33: step = mk(4, 4, 4);
        8'd34: step = mk(16, 4, 5);
        8'd35: step = mk(16, 4, 7);
        8'd36: step = mk(16, 4, 9);
        8'd37: step = mk(16, 4, 11);
        8'd38: step = mk(16, 6, 0);
        8'd39: step = mk(16, 6, 2);
        8'd40: step = mk(16, 6, 4);
        8'd41: step = mk(16, 6, 5);
        8'd42: step = mk(8, 6, 7);
        8'd43: step = mk(8, 4, 0);
        8'd44: step = mk(8, 6, 0);
        8'd45: step = mk(8, 4, 4);
        8'd46: step = mk(8, 4, 5);
        8'd47: step = mk(8, 7, 0);
        8'd48: step = mk(8, 4, 7);
        8'd49: step = mk(8, 6, 9);
        8'd50: step = mk(8, 6, 7);
        8'd51: step = mk(8, 4, 0);
        8'd52: step = mk(8, 6, 0);
        8'd53: step = mk(8, 4, 4);
        8'd54: step = mk(8, 4, 5);
        8'd55: step = mk(8, 6, 7);
        8'd56: step = mk(8, 4, 7);
        8'd57: step = mk(8, 6, 5);
        8'd58: step = mk(8, 6, 4);
        8'd59: step = mk(8, 6, 4);
        8'd60: step = mk(8, 6, 5);
        8'd61: step = mk(8, 6, 7);
        8'd62: step = mk(8, 6, 0);
        8'd63: step = mk(8, 4, 5);
        8'd64: step = mk(8, 6, 2);
        8'd65: step = mk(8, 4, 7);
        8'd66: step = mk(4, 6, 0);
        default: step = '0;
      endcase
    end
  end

endmodule

// ==== design/note_timer.sv ====
`timescale 1ns/10ps
`include "rtttl_macros.svh"

module note_timer #(
  parameter int unsigned tick_max = `RTTTL_TICK_MAX
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    run,
  input  logic                    load,
  input  logic [`RTTTL_DUR_W-1:0] load_duration,
  output logic                    step_due
);

  localparam logic [`RTTTL_TICK_W-1:0] tick_last = tick_max[`RTTTL_TICK_W-1:0];

  logic [`RTTTL_TICK_W-1:0] tick_cnt;
  logic [`RTTTL_DUR_W-1:0]  remaining;
  logic                     tick;

  // free running, wraps once per sixty-fourth note
  always_ff @(posedge clk) begin
    if (!rstn) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  assign tick = (tick_cnt == tick_last);

  // ticks left in the current step; load wins over the decrement
  always_ff @(posedge clk) begin
    if (!rstn || !run) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= load_duration;
    end else if (tick && remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign step_due = tick && run && (remaining == '0);

  tick_in_range: assert property (@(posedge clk) disable iff (!rstn) tick_cnt <= tick_last)
    else $error("tick counter passed tick_max");

  load_while_running: assert property (@(posedge clk) disable iff (!rstn) load |-> run)
    else $error("step load arrived while the sequencer was idle");

endmodule

// ==== design/rtttl_pkg.sv ====
`include "rtttl_macros.svh"

package rtttl_pkg;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_PLAY
  } seq_state_e;

  typedef enum logic {
    SONG_ZERO,
    SONG_ONE
  } song_e;

  typedef struct packed {
    logic [`RTTTL_TONE_W-1:0] octave;
    logic [`RTTTL_TONE_W-1:0] note;
  } tone_t;

  // valid low marks an address past the end of the song
  typedef struct packed {
    logic                    valid;
    logic [`RTTTL_DUR_W-1:0] duration;
    tone_t                   tone;
  } step_t;

endpackage

// ==== design/rtttl_macros.svh ====
`ifndef RTTTL_MACROS_SVH
`define RTTTL_MACROS_SVH

// last count of one sixty-fourth-note period at the default clock
`define RTTTL_TICK_MAX 23810
`define RTTTL_TICK_W 16

`define RTTTL_DUR_W 6
`define RTTTL_ADDR_W 8
// octave and note are each this wide
`define RTTTL_TONE_W 4

// step counts of the two built-in songs
`define RTTTL_SONG0_LEN 67
`define RTTTL_SONG1_LEN 62

`endif
